// ==== Bender.yml ====
package:
  name: soc_lite

sources:
  # RTL in compile order
  - soc_pkg.sv
  - soc_addr_demux.sv
  - l2_mem.sv
  - apb_bridge.sv
  - ctrl_regs.sv
  - soc_lite_top.sv

  # Testbench
  - target: test
    files:
      - tb_soc_lite.sv

// ==== apb_bridge.sv ====
`timescale 1ns/1ps
/*
  Bus to APB bridge for the UART port
  One request becomes a setup and an access phase, held until pready
*/
module apb_bridge import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  soc_req_t req_i,
  output logic     rsp_valid_o,
  output soc_rsp_t rsp_o,
  output apb_req_t apb_o,
  input  apb_rsp_t apb_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  state_e                  state_q;
  logic                    we_q;
  logic [AddrWidth-1:0]    addr_q;
  logic [ApbDataWidth-1:0] pwdata_q;
  logic                    rsp_valid_q;
  soc_rsp_t                rsp_q;

  ////////////////////
  // Transfer FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            state_q <= SETUP;
          end
        end
        SETUP: begin
          state_q <= ACCESS;
        end
        ACCESS: begin
          if (apb_i.pready) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request capture and response payload
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      we_q     <= req_i.we;
      addr_q   <= req_i.addr;
      // Address bit 2 picks the 32-bit half
      pwdata_q <= req_i.addr[2] ? req_i.wdata[DataWidth-1:ApbDataWidth]
                                : req_i.wdata[ApbDataWidth-1:0];
    end
    if (state_q == ACCESS && apb_i.pready) begin
      rsp_q.rdata <= we_q ? '0 : {apb_i.prdata, apb_i.prdata};
      rsp_q.err   <= apb_i.pslverr;
    end
  end

  assign apb_o.psel    = (state_q != IDLE);
  assign apb_o.penable = (state_q == ACCESS);
  assign apb_o.pwrite  = we_q;
  assign apb_o.paddr   = addr_q;
  assign apb_o.pwdata  = pwdata_q;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
/*
  Control registers: exit code and hardware counter enable,
  plus read-only DRAM start and end addresses
*/
module ctrl_regs import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  soc_req_t             req_i,
  output logic                 rsp_valid_o,
  output soc_rsp_t             rsp_o,
  output logic [DataWidth-1:0] exit_o,
  output logic [DataWidth-1:0] hw_cnt_en_o
);

  logic [CtrlOffWidth-1:0] offset;
  logic [DataWidth-1:0]    exit_q;
  logic [DataWidth-1:0]    cnt_en_q;
  logic                    exit_we;
  logic                    cnt_en_we;
  logic [DataWidth-1:0]    rdata_d;
  logic                    err_d;
  logic                    rsp_valid_q;
  soc_rsp_t                rsp_q;

  assign offset = req_i.addr[CtrlOffWidth-1:0];

  ////////////////////
  // Register decode
  ////////////////////

  always_comb begin
    exit_we   = 1'b0;
    cnt_en_we = 1'b0;
    rdata_d   = '0;
    err_d     = 1'b0;
    case (offset)
      CtrlExitOffset: begin
        exit_we = req_i.we;
        rdata_d = req_i.we ? '0 : exit_q;
      end
      CtrlCntEnOffset: begin
        cnt_en_we = req_i.we;
        rdata_d   = req_i.we ? '0 : cnt_en_q;
      end
      CtrlDramBaseOffset: begin
        err_d   = req_i.we;
        rdata_d = req_i.we ? '0 : DataWidth'(DramBase);
      end
      CtrlDramEndOffset: begin
        err_d   = req_i.we;
        rdata_d = req_i.we ? '0 : DataWidth'(DramBase + DramLength);
      end
      default: err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q      <= '0;
      cnt_en_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      if (req_valid_i && exit_we) begin
        exit_q <= strb_merge(exit_q, req_i.wdata, req_i.strb);
      end
      if (req_valid_i && cnt_en_we) begin
        cnt_en_q <= strb_merge(cnt_en_q, req_i.wdata, req_i.strb);
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q <= '{rdata: rdata_d, err: err_d};
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

// ==== l2_mem.sv ====
`timescale 1ns/1ps
/*
  L2 word memory, single port with byte strobes
  Answers every request one cycle later
*/
module l2_mem import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  soc_req_t req_i,
  output logic     rsp_valid_o,
  output soc_rsp_t rsp_o
);

  logic [DataWidth-1:0]  mem_q [L2NumWords];
  logic [L2IdxWidth-1:0] idx;
  logic [DataWidth-1:0]  rdata_q;
  logic                  rsp_valid_q;

  // Word index, byte offset dropped
  assign idx = req_i.addr[ByteOffWidth +: L2IdxWidth];

  ////////////////////
  // Array access
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.we) begin
        mem_q[idx] <= strb_merge(mem_q[idx], req_i.wdata, req_i.strb);
        rdata_q    <= '0;
      end else begin
        rdata_q    <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

// ==== soc_addr_demux.sv ====
`timescale 1ns/1ps
/*
  Address demux: steers the request strobe to L2, UART or control
  registers and returns the response of the selected target
*/
module soc_addr_demux import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  output logic                 rsp_valid_o,
  output soc_rsp_t             rsp_o,
  output logic                 l2_valid_o,
  output logic                 uart_valid_o,
  output logic                 ctrl_valid_o,
  input  logic                 l2_rsp_valid_i,
  input  soc_rsp_t             l2_rsp_i,
  input  logic                 uart_rsp_valid_i,
  input  soc_rsp_t             uart_rsp_i,
  input  logic                 ctrl_rsp_valid_i,
  input  soc_rsp_t             ctrl_rsp_i
);

  soc_target_e tgt_d;
  soc_target_e tgt_q;
  logic        dec_err_q;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    if (req_addr_i >= DramBase && req_addr_i < DramBase + DramLength) begin
      tgt_d = TGT_L2;
    end else if (req_addr_i >= UartBase && req_addr_i < UartBase + UartLength) begin
      tgt_d = TGT_UART;
    end else if (req_addr_i >= CtrlBase && req_addr_i < CtrlBase + CtrlLength) begin
      tgt_d = TGT_CTRL;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  assign l2_valid_o   = req_valid_i && (tgt_d == TGT_L2);
  assign uart_valid_o = req_valid_i && (tgt_d == TGT_UART);
  assign ctrl_valid_o = req_valid_i && (tgt_d == TGT_CTRL);

  // Remember target of the outstanding request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_q     <= TGT_NONE;
      dec_err_q <= 1'b0;
    end else begin
      dec_err_q <= req_valid_i && (tgt_d == TGT_NONE);
      if (req_valid_i) begin
        tgt_q <= tgt_d;
      end
    end
  end

  ////////////////////
  // Response select
  ////////////////////

  always_comb begin
    case (tgt_q)
      TGT_L2: begin
        rsp_valid_o = l2_rsp_valid_i;
        rsp_o       = l2_rsp_i;
      end
      TGT_UART: begin
        rsp_valid_o = uart_rsp_valid_i;
        rsp_o       = uart_rsp_i;
      end
      TGT_CTRL: begin
        rsp_valid_o = ctrl_rsp_valid_i;
        rsp_o       = ctrl_rsp_i;
      end
      default: begin
        // Decode error, nothing was accessed
        rsp_valid_o = dec_err_q;
        rsp_o       = '{rdata: '0, err: 1'b1};
      end
    endcase
  end

endmodule

// ==== soc_lite.f ====
soc_pkg.sv
soc_addr_demux.sv
l2_mem.sv
apb_bridge.sv
ctrl_regs.sv
soc_lite_top.sv
tb_soc_lite.sv

// ==== soc_lite_top.sv ====
`timescale 1ns/1ps
/*
  soc_lite top level
  One bus master port routed to L2, UART APB and control registers
*/
module soc_lite_top import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  soc_req_t             req_i,
  output logic                 rsp_valid_o,
  output soc_rsp_t             rsp_o,
  output logic [DataWidth-1:0] exit_o,
  output logic [DataWidth-1:0] hw_cnt_en_o,
  output apb_req_t             uart_apb_o,
  input  apb_rsp_t             uart_apb_i
);

  logic     l2_valid;
  logic     uart_valid;
  logic     ctrl_valid;
  logic     l2_rsp_valid;
  logic     uart_rsp_valid;
  logic     ctrl_rsp_valid;
  soc_rsp_t l2_rsp;
  soc_rsp_t uart_rsp;
  soc_rsp_t ctrl_rsp;

  soc_addr_demux i_demux (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .req_valid_i     (req_valid_i   ),
    .req_addr_i      (req_i.addr    ),
    .rsp_valid_o     (rsp_valid_o   ),
    .rsp_o           (rsp_o         ),
    .l2_valid_o      (l2_valid      ),
    .uart_valid_o    (uart_valid    ),
    .ctrl_valid_o    (ctrl_valid    ),
    .l2_rsp_valid_i  (l2_rsp_valid  ),
    .l2_rsp_i        (l2_rsp        ),
    .uart_rsp_valid_i(uart_rsp_valid),
    .uart_rsp_i      (uart_rsp      ),
    .ctrl_rsp_valid_i(ctrl_rsp_valid),
    .ctrl_rsp_i      (ctrl_rsp      )
  );

  l2_mem i_l2_mem (
    .clk_i      (clk_i       ),
    .rst_n_i    (rst_n_i     ),
    .req_valid_i(l2_valid    ),
    .req_i      (req_i       ),
    .rsp_valid_o(l2_rsp_valid),
    .rsp_o      (l2_rsp      )
  );

  apb_bridge i_uart_bridge (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .req_valid_i(uart_valid    ),
    .req_i      (req_i         ),
    .rsp_valid_o(uart_rsp_valid),
    .rsp_o      (uart_rsp      ),
    .apb_o      (uart_apb_o    ),
    .apb_i      (uart_apb_i    )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .req_valid_i(ctrl_valid    ),
    .req_i      (req_i         ),
    .rsp_valid_o(ctrl_rsp_valid),
    .rsp_o      (ctrl_rsp      ),
    .exit_o     (exit_o        ),
    .hw_cnt_en_o(hw_cnt_en_o   )
  );

endmodule

// ==== soc_pkg.sv ====
/*
  soc_lite shared definitions
  Address map, bus widths, target selector and the packed
  request and response structs of the internal bus and APB port
*/
package soc_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned L2NumWords   = 1024;

  // Word index into L2 sits above the byte offset
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);
  localparam int unsigned L2IdxWidth   = $clog2(L2NumWords);

  ////////////////////
  // Memory map
  ////////////////////

  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h0000_2000;
  localparam logic [AddrWidth-1:0] UartBase   = 32'hC000_0000;
  localparam logic [AddrWidth-1:0] UartLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] CtrlBase   = 32'hD000_0000;
  localparam logic [AddrWidth-1:0] CtrlLength = 32'h0000_1000;

  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_UART = 2'd1,
    TGT_CTRL = 2'd2,
    TGT_NONE = 2'd3
  } soc_target_e;

  // Control register offsets inside the control region
  localparam int unsigned CtrlOffWidth = $clog2(CtrlLength);

  localparam logic [CtrlOffWidth-1:0] CtrlExitOffset     = 'h00;
  localparam logic [CtrlOffWidth-1:0] CtrlCntEnOffset    = 'h08;
  localparam logic [CtrlOffWidth-1:0] CtrlDramBaseOffset = 'h10;
  localparam logic [CtrlOffWidth-1:0] CtrlDramEndOffset  = 'h18;

  ////////////////////
  // Bus structs
  ////////////////////

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } soc_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } soc_rsp_t;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [AddrWidth-1:0]    paddr;
    logic [ApbDataWidth-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [ApbDataWidth-1:0] prdata;
    logic                    pready;
    logic                    pslverr;
  } apb_rsp_t;

  // Byte lanes with a set strobe take the new data
  function automatic logic [DataWidth-1:0] strb_merge(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] new_data,
    input logic [StrbWidth-1:0] strb
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== tb_soc_lite.sv ====
`timescale 1ns/1ps
/*
  soc_lite testbench
  Bus master, APB device model and checks on L2, UART and control targets
*/
module tb_soc_lite import soc_pkg::*; ();

  localparam int unsigned          RspTimeout  = 64;
  localparam logic [AddrWidth-1:0] UartErrAddr = UartBase + 32'h3c;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    req_valid_i;
  soc_req_t                req_i;
  logic                    rsp_valid_o;
  soc_rsp_t                rsp_o;
  logic [DataWidth-1:0]    exit_o;
  logic [DataWidth-1:0]    hw_cnt_en_o;
  apb_req_t                uart_apb_o;
  apb_rsp_t                uart_apb_i = '0;

  int unsigned             n_checks;
  int unsigned             n_errors;
  int unsigned             wait_left = 0;
  logic [AddrWidth-1:0]    exp_paddr;
  logic [ApbDataWidth-1:0] exp_pwdata;
  logic                    exp_pwrite;
  logic [ApbDataWidth-1:0] apb_regs [16];
  logic [DataWidth-1:0]    l2_model [L2NumWords];

  soc_lite_top uut (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic logic in_region(input logic [AddrWidth-1:0] a,
                                     input logic [AddrWidth-1:0] base,
                                     input logic [AddrWidth-1:0] len);
    return (a >= base) && ((a - base) < len);
  endfunction

  function automatic logic unmapped(input logic [AddrWidth-1:0] a);
    return !in_region(a, DramBase, DramLength) && !in_region(a, UartBase, UartLength) &&
           !in_region(a, CtrlBase, CtrlLength);
  endfunction

  // Strobe bits widened to a byte mask
  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_w,
                                                       input logic [DataWidth-1:0] new_w,
                                                       input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    for (int b = 0; b < StrbWidth; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (new_w & mask) | (old_w & ~mask);
  endfunction

  task automatic check_val(input string name, input logic [DataWidth-1:0] exp,
                           input logic [DataWidth-1:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  ////////////////////
  // Timing checks
  ////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && !in_region(req_i.addr, UartBase, UartLength)) |=> rsp_valid_o)
    else begin
      n_errors++;
      $display("ERR %0t rsp_valid_o expected 1 got %b", $time, $sampled(rsp_valid_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && in_region(req_i.addr, DramBase, DramLength)) |=> !rsp_o.err)
    else begin
      n_errors++;
      $display("ERR %0t rsp_o.err expected 0 got %b", $time, $sampled(rsp_o.err));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && unmapped(req_i.addr)) |=> !uart_apb_o.psel)
    else begin
      n_errors++;
      $display("ERR %0t psel expected 0 got %b", $time, $sampled(uart_apb_o.psel));
    end

  // Transfer starts with a setup phase
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uart_apb_o.psel) |-> !uart_apb_o.penable)
    else begin
      n_errors++;
      $display("ERR %0t penable expected 0 got %b", $time, $sampled(uart_apb_o.penable));
    end

  // Setup phase always leads into access
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (uart_apb_o.psel && !uart_apb_o.penable) |=> uart_apb_o.penable)
    else begin
      n_errors++;
      $display("ERR %0t penable expected 1 got %b", $time, $sampled(uart_apb_o.penable));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uart_apb_o.psel) |-> (uart_apb_o.paddr == exp_paddr))
    else begin
      n_errors++;
      $display("ERR %0t paddr expected %h got %h", $time, exp_paddr,
               $sampled(uart_apb_o.paddr));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uart_apb_o.psel) |-> (uart_apb_o.pwrite == exp_pwrite))
    else begin
      n_errors++;
      $display("ERR %0t pwrite expected %b got %b", $time, exp_pwrite,
               $sampled(uart_apb_o.pwrite));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(uart_apb_o.psel) |-> (uart_apb_o.pwdata == exp_pwdata))
    else begin
      n_errors++;
      $display("ERR %0t pwdata expected %h got %h", $time, exp_pwdata,
               $sampled(uart_apb_o.pwdata));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (uart_apb_o.penable && uart_apb_i.pready) |=> rsp_valid_o)
    else begin
      n_errors++;
      $display("ERR %0t rsp_valid_o expected 1 got %b", $time, $sampled(rsp_valid_o));
    end

  ////////////////////
  // APB device model
  ////////////////////

  always @(posedge clk_i) begin
    logic        done;
    logic [3:0]  ridx;
    int unsigned w;
    done = 1'b0;
    ridx = uart_apb_o.paddr[5:2];
    if (uart_apb_i.pready) begin
      uart_apb_i.pready  <= 1'b0;
      uart_apb_i.pslverr <= 1'b0;
    end else if (uart_apb_o.psel && !uart_apb_o.penable) begin
      w         = $urandom_range(0, 3);
      done      = (w == 0);
      wait_left <= w;
    end else if (uart_apb_o.psel && uart_apb_o.penable) begin
      done      = (wait_left <= 1);
      wait_left <= wait_left - 1;
    end
    if (done) begin
      uart_apb_i.pready  <= 1'b1;
      uart_apb_i.pslverr <= (uart_apb_o.paddr == UartErrAddr);
      uart_apb_i.prdata  <= apb_regs[ridx];
      if (uart_apb_o.pwrite && uart_apb_o.paddr != UartErrAddr) begin
        apb_regs[ridx] <= uart_apb_o.pwdata;
      end
    end
  end

  // One request, then wait for the response strobe
  task automatic bus_access(input logic we, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] wdata,
                            input logic [StrbWidth-1:0] strb,
                            output soc_rsp_t rsp, output int unsigned latency);
    int unsigned cycles;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= '{we: we, addr: addr, wdata: wdata, strb: strb};
    exp_paddr   <= addr;
    exp_pwrite  <= we;
    exp_pwdata  <= addr[2] ? wdata[63:32] : wdata[31:0];
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    cycles = 1;
    @(negedge clk_i);
    while (!rsp_valid_o && cycles < RspTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!rsp_valid_o) begin
      n_errors++;
      $display("No response within %0d cycles for address %h", RspTimeout, addr);
      $display("checks %0d, errors %0d", n_checks, n_errors);
      $display("TEST FAILED");
      $finish;
    end else begin
      rsp     = rsp_o;
      latency = cycles;
    end
  endtask

  initial begin
    soc_rsp_t                rsp;
    int unsigned             lat;
    int unsigned             idx [8];
    logic [DataWidth-1:0]    wd;
    logic [StrbWidth-1:0]    st;
    logic [AddrWidth-1:0]    ua;
    logic [ApbDataWidth-1:0] half;
    logic [DataWidth-1:0]    exp_exit;
    logic [DataWidth-1:0]    exp_cnt;
    void'($urandom(32'hfdb7));
    n_checks    = 0;
    n_errors    = 0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    exp_paddr   = '0;
    exp_pwrite  = 1'b0;
    exp_pwdata  = '0;
    for (int i = 0; i < 16; i++) apb_regs[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("rsp_valid_o", 0, rsp_valid_o);
    check_val("psel", 0, uart_apb_o.psel);
    check_val("penable", 0, uart_apb_o.penable);
    check_val("exit_o", 0, exit_o);
    check_val("hw_cnt_en_o", 0, hw_cnt_en_o);

    // L2: full writes, partial writes, then read back
    for (int k = 0; k < 8; k++) begin
      idx[k] = $urandom_range(0, L2NumWords - 1);
      wd     = {$urandom, $urandom};
      bus_access(1'b1, DramBase + idx[k] * 8, wd, '1, rsp, lat);
      l2_model[idx[k]] = wd;
      check_val("l2 latency", 1, lat);
    end
    for (int k = 0; k < 8; k++) begin
      wd = {$urandom, $urandom};
      st = $urandom_range(1, 254);
      bus_access(1'b1, DramBase + idx[k] * 8, wd, st, rsp, lat);
      l2_model[idx[k]] = merge_bytes(l2_model[idx[k]], wd, st);
    end
    for (int k = 0; k < 8; k++) begin
      bus_access(1'b0, DramBase + idx[k] * 8, '0, '0, rsp, lat);
      check_val("l2 rdata", l2_model[idx[k]], rsp.rdata);
      check_val("l2 err", 0, rsp.err);
      check_val("l2 latency", 1, lat);
    end

    ////////////////////
    // Control registers
    ////////////////////
    exp_exit = 64'h0123_4567_89ab_cdef;
    bus_access(1'b1, CtrlBase + CtrlExitOffset, exp_exit, '1, rsp, lat);
    check_val("exit_o", exp_exit, exit_o);
    wd = 64'hffee_ddcc_bbaa_9988;
    bus_access(1'b1, CtrlBase + CtrlExitOffset, wd, 8'h0f, rsp, lat);
    exp_exit = merge_bytes(exp_exit, wd, 8'h0f);
    check_val("exit_o", exp_exit, exit_o);
    wd = {$urandom, $urandom};
    bus_access(1'b1, CtrlBase + CtrlCntEnOffset, wd, 8'hf0, rsp, lat);
    exp_cnt = merge_bytes('0, wd, 8'hf0);
    wd = {$urandom, $urandom};
    bus_access(1'b1, CtrlBase + CtrlCntEnOffset, wd, 8'h3c, rsp, lat);
    exp_cnt = merge_bytes(exp_cnt, wd, 8'h3c);
    check_val("hw_cnt_en_o", exp_cnt, hw_cnt_en_o);
    bus_access(1'b0, CtrlBase + CtrlExitOffset, '0, '0, rsp, lat);
    check_val("ctrl exit rdata", exp_exit, rsp.rdata);
    bus_access(1'b0, CtrlBase + CtrlDramBaseOffset, '0, '0, rsp, lat);
    check_val("ctrl dram base", 64'h8000_0000, rsp.rdata);
    check_val("ctrl latency", 1, lat);
    bus_access(1'b0, CtrlBase + CtrlDramEndOffset, '0, '0, rsp, lat);
    check_val("ctrl dram end", 64'h8000_2000, rsp.rdata);
    bus_access(1'b1, CtrlBase + CtrlDramBaseOffset, '1, '1, rsp, lat);
    check_val("ctrl ro err", 1, rsp.err);
    check_val("exit_o", exp_exit, exit_o);
    check_val("hw_cnt_en_o", exp_cnt, hw_cnt_en_o);
    bus_access(1'b0, CtrlBase + 32'h20, '0, '0, rsp, lat);
    check_val("ctrl unknown err", 1, rsp.err);

    // Unmapped addresses
    bus_access(1'b0, 32'h4000_0000, '0, '0, rsp, lat);
    check_val("decode err", 1, rsp.err);
    check_val("decode rdata", 0, rsp.rdata);
    check_val("decode latency", 1, lat);
    bus_access(1'b1, 32'h9000_0000, '1, '1, rsp, lat);
    check_val("decode err", 1, rsp.err);

    ////////////////////
    // UART over APB
    ////////////////////
    for (int k = 0; k < 6; k++) begin
      ua   = UartBase + $urandom_range(0, 7) * 4;
      wd   = {$urandom, $urandom};
      half = ua[2] ? wd[63:32] : wd[31:0];
      bus_access(1'b1, ua, wd, '1, rsp, lat);
      check_val("uart write err", 0, rsp.err);
      bus_access(1'b0, ua, '0, '0, rsp, lat);
      check_val("uart rdata", {half, half}, rsp.rdata);
      check_val("uart read err", 0, rsp.err);
    end
    half = apb_regs[8];
    bus_access(1'b0, UartBase + 32'h20, '0, '0, rsp, lat);
    check_val("uart rdata", {half, half}, rsp.rdata);
    bus_access(1'b1, UartErrAddr, {$urandom, $urandom}, '1, rsp, lat);
    check_val("uart slverr", 1, rsp.err);
    bus_access(1'b0, UartErrAddr, '0, '0, rsp, lat);
    check_val("uart slverr", 1, rsp.err);

    repeat (2) @(posedge clk_i);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
